// ==== build.f ====
+incdir+testbench
logic/mips_pkg.sv
logic/mips_decode.sv
logic/mips_execute.sv
logic/mips_writeback.sv
logic/mips_core.sv
testbench/tb_mips_core.sv

// ==== Makefile ====
# Verilator build, run and lint of the MIPS datapath

VERILATOR ?= verilator
TOP       ?= tb_mips_core
LINT_TOP  ?= mips_core
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?=

FAIL_MSG  := Something failed
PASS_MSG  := Everything OK

SOURCES := $(wildcard logic/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing --timescale 1ns/1ns -j $(JOBS) $(VFLAGS) \
		--top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, not the exit status of the binary
run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ns -Wall $(VFLAGS) \
		--top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/tb_mips_table.svh ====
`ifndef TB_MIPS_TABLE_SVH
`define TB_MIPS_TABLE_SVH

// Each row is an instruction word, a write flag, the destination register and the value written
typedef struct packed {
	mips_pkg::instr_t    instr;
	logic                write;
	mips_pkg::reg_addr_t dest;
	mips_pkg::data_t     value;
} row_t;

localparam int ROW_COUNT   = 36;
localparam int BURST_FIRST = 18;    // Rows sent back to back
localparam int BURST_LAST  = 29;

row_t rows [ROW_COUNT] = '{
	// Immediates and extension
	'{32'h2001_0005, 1'b1, 5'd1,  32'h0000_0005},  // addi r1, r0, 5
	'{32'h2002_FFFD, 1'b1, 5'd2,  32'hFFFF_FFFD},  // addi r2, r0, -3
	'{32'h2023_FFFF, 1'b1, 5'd3,  32'h0000_0004},  // addi r3, r1, -1
	'{32'h3404_8001, 1'b1, 5'd4,  32'h0000_8001},  // ori  r4, r0, 0x8001
	'{32'h3045_8F0F, 1'b1, 5'd5,  32'h0000_8F0D},  // andi r5, r2, 0x8f0f
	'{32'h3C06_1234, 1'b1, 5'd6,  32'h1234_0000},  // lui  r6, 0x1234
	'{32'h34C6_ABCD, 1'b1, 5'd6,  32'h1234_ABCD},  // ori  r6, r6, 0xabcd
	// R-type
	'{32'h0023_3820, 1'b1, 5'd7,  32'h0000_0009},  // add  r7, r1, r3
	'{32'h0061_4022, 1'b1, 5'd8,  32'hFFFF_FFFF},  // sub  r8, r3, r1
	'{32'h00C5_4824, 1'b1, 5'd9,  32'h0000_8B0D},  // and  r9, r6, r5
	'{32'h00C5_5025, 1'b1, 5'd10, 32'h1234_AFCD},  // or   r10, r6, r5
	'{32'h0041_582A, 1'b1, 5'd11, 32'h0000_0001},  // slt  r11, r2, r1
	'{32'h0022_602A, 1'b1, 5'd12, 32'h0000_0000},  // slt  r12, r1, r2
	// Bubbles and then a read of the untouched r13
	'{32'h2020_0007, 1'b0, 5'd0,  32'h0000_0000},  // addi r0, r1, 7
	'{32'h8C2D_0000, 1'b0, 5'd0,  32'h0000_0000},  // lw   r13, 0(r1)
	'{32'h0022_6826, 1'b0, 5'd0,  32'h0000_0000},  // xor  r13, r1, r2
	'{32'h0022_0020, 1'b0, 5'd0,  32'h0000_0000},  // add  r0, r1, r2
	'{32'h01A1_7020, 1'b1, 5'd14, 32'h0000_0005},  // add  r14, r13, r1
	// Dependent chain without idle cycles
	'{32'h200F_0064, 1'b1, 5'd15, 32'h0000_0064},  // addi r15, r0, 100
	'{32'h21EF_0001, 1'b1, 5'd15, 32'h0000_0065},  // addi r15, r15, 1
	'{32'h01EF_8020, 1'b1, 5'd16, 32'h0000_00CA},  // add  r16, r15, r15
	'{32'h020F_8822, 1'b1, 5'd17, 32'h0000_0065},  // sub  r17, r16, r15
	'{32'h0230_9025, 1'b1, 5'd18, 32'h0000_00EF},  // or   r18, r17, r16
	'{32'h0250_9824, 1'b1, 5'd19, 32'h0000_00CA},  // and  r19, r18, r16
	'{32'h0233_A020, 1'b1, 5'd20, 32'h0000_012F},  // add  r20, r17, r19
	'{32'h028F_7822, 1'b1, 5'd15, 32'h0000_00CA},  // sub  r15, r20, r15
	'{32'hAC0F_0004, 1'b0, 5'd0,  32'h0000_0000},  // sw   r15, 4(r0)
	'{32'h21F5_0002, 1'b1, 5'd21, 32'h0000_00CC},  // addi r21, r15, 2
	'{32'h02B5_0020, 1'b0, 5'd0,  32'h0000_0000},  // add  r0, r21, r21
	'{32'h01F5_B02A, 1'b1, 5'd22, 32'h0000_0001},  // slt  r22, r15, r21
	// Sign edge cases
	'{32'h3C17_8000, 1'b1, 5'd23, 32'h8000_0000},  // lui  r23, 0x8000
	'{32'h02E1_C02A, 1'b1, 5'd24, 32'h0000_0001},  // slt  r24, r23, r1
	'{32'h22F9_FFFF, 1'b1, 5'd25, 32'h7FFF_FFFF},  // addi r25, r23, -1
	'{32'h02F9_D022, 1'b1, 5'd26, 32'h0000_0001},  // sub  r26, r23, r25
	'{32'h201F_7FFF, 1'b1, 5'd31, 32'h0000_7FFF},  // addi r31, r0, 0x7fff
	'{32'h03E6_D825, 1'b1, 5'd27, 32'h1234_FFFF}   // or   r27, r31, r6
};

`endif

// ==== testbench/tb_mips_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mips_core;

	localparam int CLK_PERIOD   = 100;
	localparam int DRIVE_DELAY  = 10;
	localparam int RESET_CYCLES = 16;

	logic                clk;
	logic                reset;
	logic                instr_valid;
	mips_pkg::instr_t    instr;
	logic                wb_valid;
	mips_pkg::reg_addr_t wb_addr;
	mips_pkg::data_t     wb_data;

	`include "tb_mips_table.svh"

	// Worst case is 3 idle cycles per row
	localparam int WATCHDOG_CYCLES = ROW_COUNT * 4 + RESET_CYCLES + 20;

	typedef struct packed {
		int                  row;
		mips_pkg::reg_addr_t dest;
		mips_pkg::data_t     value;
		int unsigned         due_edge;
	} expect_t;

	expect_t     pending [$];         // Writes still to be reported
	int unsigned cyc = 0;             // Rising edges so far
	int unsigned lcg_state = 15;
	logic        report_due;

	mips_core i_dut (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb_valid    (wb_valid),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data)
	);

	// ------------------------------------------------------------
	// Clock and edge count
	// ------------------------------------------------------------
	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2);
			clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	function automatic int unsigned next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("Something failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// ------------------------------------------------------------
	// Drivers
	// ------------------------------------------------------------
	task automatic send_instr(input int idx);
		expect_t item;
		@(posedge clk);
		#DRIVE_DELAY;
		instr_valid = 1'b1;
		instr       = rows[idx].instr;
		if (rows[idx].write) begin
			item.row      = idx;
			item.dest     = rows[idx].dest;
			item.value    = rows[idx].value;
			item.due_edge = cyc + 4;    // Sampled at the next edge and reported 3 edges later
			pending.push_back(item);
		end
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
		instr_valid = 1'b0;
		instr       = next_rand();      // Garbage while not valid
	endtask

	initial begin
		int gap;
		reset       = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
		repeat (4) idle_cycle();        // Nothing may be reported here
		for (int r = 0; r < ROW_COUNT; r++) begin
			send_instr(r);
			if (r >= BURST_FIRST && r < BURST_LAST) begin
				gap = 0;
			end else begin
				gap = int'(next_rand() >> 30);  // 0 to 3 idle cycles
			end
			repeat (gap) idle_cycle();
		end
		idle_cycle();
		repeat (5) @(posedge clk);      // Drain the pipeline
		$display("Everything OK");
		$finish;
	end

	// ------------------------------------------------------------
	// Monitor
	// ------------------------------------------------------------
	// Outputs are looked at mid-cycle and a report here is seen at edge cyc + 1
	always @(negedge clk) begin
		if (!reset) begin
			report_due = (pending.size() != 0) && (pending[0].due_edge == cyc + 1);
			check_value("wb_valid", 32'(wb_valid), 32'(report_due));
			if (report_due) begin
				check_value($sformatf("wb_addr of row %0d", pending[0].row),
					32'(wb_addr), 32'(pending[0].dest));
				check_value($sformatf("wb_data of row %0d", pending[0].row),
					wb_data, pending[0].value);
				void'(pending.pop_front());
			end
		end
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Something failed");
		$fatal(1, "Watchdog expired");
	end

endmodule

`default_nettype wire

// ==== logic/mips_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module mips_core (
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire logic               instr_valid,
	input  mips_pkg::instr_t        instr,
	output logic                    wb_valid,
	output mips_pkg::reg_addr_t     wb_addr,
	output mips_pkg::data_t         wb_data
);

	// Bank read port
	mips_pkg::reg_addr_t rd_addr_a;
	mips_pkg::reg_addr_t rd_addr_b;
	mips_pkg::data_t     rd_data_a;
	mips_pkg::data_t     rd_data_b;

	// Decode to execute
	logic                dec_valid;
	logic                dec_write;
	mips_pkg::reg_addr_t dec_dest;
	mips_pkg::reg_addr_t dec_rs;
	mips_pkg::reg_addr_t dec_rt;
	mips_pkg::alu_op_e   dec_alu_op;
	mips_pkg::data_t     dec_data_a;
	mips_pkg::data_t     dec_data_b;
	mips_pkg::data_t     dec_imm;
	logic                dec_use_imm;

	// Execute to result
	logic                exe_write;
	mips_pkg::reg_addr_t exe_dest;
	mips_pkg::data_t     exe_data;

	// ------------------------------------------------------------
	// Stages
	// ------------------------------------------------------------
	mips_decode i_decode (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.rd_data_a   (rd_data_a),
		.rd_data_b   (rd_data_b),
		.rd_addr_a   (rd_addr_a),
		.rd_addr_b   (rd_addr_b),
		.dec_valid   (dec_valid),
		.dec_write   (dec_write),
		.dec_dest    (dec_dest),
		.dec_rs      (dec_rs),
		.dec_rt      (dec_rt),
		.dec_alu_op  (dec_alu_op),
		.dec_data_a  (dec_data_a),
		.dec_data_b  (dec_data_b),
		.dec_imm     (dec_imm),
		.dec_use_imm (dec_use_imm)
	);

	mips_execute i_execute (
		.clk         (clk),
		.reset       (reset),
		.dec_valid   (dec_valid),
		.dec_write   (dec_write),
		.dec_dest    (dec_dest),
		.dec_rs      (dec_rs),
		.dec_rt      (dec_rt),
		.dec_alu_op  (dec_alu_op),
		.dec_data_a  (dec_data_a),
		.dec_data_b  (dec_data_b),
		.dec_imm     (dec_imm),
		.dec_use_imm (dec_use_imm),
		.wb_valid    (wb_valid),     // Forwarding path
		.wb_addr     (wb_addr),
		.wb_data     (wb_data),
		.exe_write   (exe_write),
		.exe_dest    (exe_dest),
		.exe_data    (exe_data)
	);

	mips_writeback i_writeback (
		.clk       (clk),
		.reset     (reset),
		.exe_write (exe_write),
		.exe_dest  (exe_dest),
		.exe_data  (exe_data),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wb_valid  (wb_valid),
		.wb_addr   (wb_addr),
		.wb_data   (wb_data)
	);

endmodule

`default_nettype wire

// ==== logic/mips_writeback.sv ====
`timescale 1ns/1ns
`default_nettype none

module mips_writeback (
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire logic               exe_write,
	input  mips_pkg::reg_addr_t     exe_dest,
	input  mips_pkg::data_t         exe_data,
	input  mips_pkg::reg_addr_t     rd_addr_a,
	input  mips_pkg::reg_addr_t     rd_addr_b,
	output mips_pkg::data_t         rd_data_a,
	output mips_pkg::data_t         rd_data_b,
	output logic                    wb_valid,
	output mips_pkg::reg_addr_t     wb_addr,
	output mips_pkg::data_t         wb_data
);

	mips_pkg::data_t bank [mips_pkg::REG_COUNT];

	logic hit_a;
	logic hit_b;

	// ------------------------------------------------------------
	// Result register
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_valid <= 1'b0;
			wb_addr  <= '0;
			wb_data  <= '0;
		end else begin
			wb_valid <= exe_write;
			wb_addr  <= exe_dest;
			wb_data  <= exe_data;
		end
	end

	// ------------------------------------------------------------
	// Register bank
	// ------------------------------------------------------------
	// r0 is never addressed by a write, so it stays zero
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < mips_pkg::REG_COUNT; i++) begin
				bank[i] <= '0;
			end
		end else if (wb_valid) begin
			bank[wb_addr] <= wb_data;   // One cycle after the report
		end
	end

	// Write-through when decode reads the register being written
	assign hit_a = wb_valid && (wb_addr == rd_addr_a);
	assign hit_b = wb_valid && (wb_addr == rd_addr_b);

	assign rd_data_a = hit_a ? wb_data : bank[rd_addr_a];
	assign rd_data_b = hit_b ? wb_data : bank[rd_addr_b];

endmodule

`default_nettype wire

// ==== logic/mips_execute.sv ====
`timescale 1ns/1ns
`default_nettype none

module mips_execute (
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire logic               dec_valid,
	input  wire logic               dec_write,
	input  mips_pkg::reg_addr_t     dec_dest,
	input  mips_pkg::reg_addr_t     dec_rs,
	input  mips_pkg::reg_addr_t     dec_rt,
	input  mips_pkg::alu_op_e       dec_alu_op,
	input  mips_pkg::data_t         dec_data_a,
	input  mips_pkg::data_t         dec_data_b,
	input  mips_pkg::data_t         dec_imm,
	input  wire logic               dec_use_imm,
	input  wire logic               wb_valid,
	input  mips_pkg::reg_addr_t     wb_addr,
	input  mips_pkg::data_t         wb_data,
	output logic                    exe_write,
	output mips_pkg::reg_addr_t     exe_dest,
	output mips_pkg::data_t         exe_data
);

	logic                write_q;
	mips_pkg::reg_addr_t dest_q;
	mips_pkg::reg_addr_t rs_q;
	mips_pkg::reg_addr_t rt_q;
	mips_pkg::alu_op_e   alu_op_q;
	mips_pkg::data_t     data_a_q;
	mips_pkg::data_t     data_b_q;
	mips_pkg::data_t     imm_q;
	logic                use_imm_q;

	mips_pkg::data_t     op_a;
	mips_pkg::data_t     fwd_b;
	mips_pkg::data_t     op_b;

	// ------------------------------------------------------------
	// Execute register
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			write_q <= 1'b0;
		end else begin
			write_q <= dec_write;
		end
	end

	// Payload only moves for a real instruction
	always_ff @(posedge clk) begin
		if (dec_valid) begin
			dest_q    <= dec_dest;
			rs_q      <= dec_rs;
			rt_q      <= dec_rt;
			alu_op_q  <= dec_alu_op;
			data_a_q  <= dec_data_a;
			data_b_q  <= dec_data_b;
			imm_q     <= dec_imm;
			use_imm_q <= dec_use_imm;
		end
	end

	// ------------------------------------------------------------
	// Forwarding from the result stage
	// ------------------------------------------------------------
	// Older results already came in through the bank or write-through
	assign op_a  = (wb_valid && wb_addr == rs_q) ? wb_data : data_a_q;
	assign fwd_b = (wb_valid && wb_addr == rt_q) ? wb_data : data_b_q;
	assign op_b  = use_imm_q ? imm_q : fwd_b;

	// ------------------------------------------------------------
	// ALU
	// ------------------------------------------------------------
	always_comb begin
		case (alu_op_q)
			mips_pkg::ALU_ADD: exe_data = op_a + op_b;
			mips_pkg::ALU_SUB: exe_data = op_a - op_b;
			mips_pkg::ALU_AND: exe_data = op_a & op_b;
			mips_pkg::ALU_OR:  exe_data = op_a | op_b;
			mips_pkg::ALU_SLT: begin
				// Signed compare, result is 0 or 1
				exe_data = ($signed(op_a) < $signed(op_b)) ?
					mips_pkg::data_t'(1) : '0;
			end
			mips_pkg::ALU_LUI: exe_data = op_b << mips_pkg::IMM_W;
			default:           exe_data = '0;
		endcase
	end

	assign exe_write = write_q;
	assign exe_dest  = dest_q;

endmodule

`default_nettype wire

// ==== logic/mips_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module mips_decode (
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire logic               instr_valid,
	input  mips_pkg::instr_t        instr,
	input  mips_pkg::data_t         rd_data_a,
	input  mips_pkg::data_t         rd_data_b,
	output mips_pkg::reg_addr_t     rd_addr_a,
	output mips_pkg::reg_addr_t     rd_addr_b,
	output logic                    dec_valid,
	output logic                    dec_write,
	output mips_pkg::reg_addr_t     dec_dest,
	output mips_pkg::reg_addr_t     dec_rs,
	output mips_pkg::reg_addr_t     dec_rt,
	output mips_pkg::alu_op_e       dec_alu_op,
	output mips_pkg::data_t         dec_data_a,
	output mips_pkg::data_t         dec_data_b,
	output mips_pkg::data_t         dec_imm,
	output logic                    dec_use_imm
);

	logic                valid_q;
	mips_pkg::instr_t    instr_q;

	mips_pkg::opcode_t   opcode;
	mips_pkg::funct_t    funct;
	mips_pkg::imm_t      imm;
	mips_pkg::reg_addr_t rd;
	logic                supported;
	logic                sign_ext;
	logic                dest_rd;

	// ------------------------------------------------------------
	// Decode register
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= instr_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			instr_q <= instr;
		end
	end

	// Field split
	assign opcode = instr_q[mips_pkg::OPCODE_LSB +: mips_pkg::OPCODE_W];
	assign funct  = instr_q[mips_pkg::FUNCT_W-1:0];
	assign imm    = instr_q[mips_pkg::IMM_W-1:0];
	assign dec_rs = instr_q[mips_pkg::RS_LSB +: mips_pkg::REG_ADDR_W];
	assign dec_rt = instr_q[mips_pkg::RT_LSB +: mips_pkg::REG_ADDR_W];
	assign rd     = instr_q[mips_pkg::RD_LSB +: mips_pkg::REG_ADDR_W];

	// ------------------------------------------------------------
	// Control decode
	// ------------------------------------------------------------
	always_comb begin
		supported   = 1'b0;
		sign_ext    = 1'b0;
		dest_rd     = 1'b0;
		dec_use_imm = 1'b0;
		dec_alu_op  = mips_pkg::ALU_ADD;
		case (opcode)
			mips_pkg::OP_RTYPE: begin
				dest_rd = 1'b1;
				supported = 1'b1;   // Cleared below for unknown funct
				case (funct)
					mips_pkg::FUNCT_ADD: dec_alu_op = mips_pkg::ALU_ADD;
					mips_pkg::FUNCT_SUB: dec_alu_op = mips_pkg::ALU_SUB;
					mips_pkg::FUNCT_AND: dec_alu_op = mips_pkg::ALU_AND;
					mips_pkg::FUNCT_OR:  dec_alu_op = mips_pkg::ALU_OR;
					mips_pkg::FUNCT_SLT: dec_alu_op = mips_pkg::ALU_SLT;
					default:             supported = 1'b0;
				endcase
			end
			mips_pkg::OP_ADDI: begin
				supported   = 1'b1;
				sign_ext    = 1'b1;
				dec_use_imm = 1'b1;
				dec_alu_op  = mips_pkg::ALU_ADD;
			end
			mips_pkg::OP_ANDI: begin
				supported   = 1'b1;
				dec_use_imm = 1'b1;
				dec_alu_op  = mips_pkg::ALU_AND;
			end
			mips_pkg::OP_ORI: begin
				supported   = 1'b1;
				dec_use_imm = 1'b1;
				dec_alu_op  = mips_pkg::ALU_OR;
			end
			mips_pkg::OP_LUI: begin
				supported   = 1'b1;
				dec_use_imm = 1'b1;
				dec_alu_op  = mips_pkg::ALU_LUI;
			end
			default: ;  // Bubble
		endcase
	end

	assign dec_valid = valid_q & supported;
	assign dec_dest  = dest_rd ? rd : dec_rt;
	assign dec_write = dec_valid & (dec_dest != '0);  // Writes to r0 dropped here only

	// Only ADDI sign-extends
	assign dec_imm = sign_ext ?
		{{(mips_pkg::DATA_W-mips_pkg::IMM_W){imm[mips_pkg::IMM_W-1]}}, imm} :
		{{(mips_pkg::DATA_W-mips_pkg::IMM_W){1'b0}}, imm};

	// Operand read from the bank
	assign rd_addr_a  = dec_rs;
	assign rd_addr_b  = dec_rt;
	assign dec_data_a = rd_data_a;
	assign dec_data_b = rd_data_b;

endmodule

`default_nettype wire

// ==== logic/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

	// ------------------------------------------------------------
	// Widths
	// ------------------------------------------------------------
	localparam int REG_COUNT  = 32;
	localparam int REG_ADDR_W = $clog2(REG_COUNT);
	localparam int DATA_W     = 32;
	localparam int INSTR_W    = 32;
	localparam int OPCODE_W   = 6;
	localparam int FUNCT_W    = 6;
	localparam int IMM_W      = 16;

	typedef logic [DATA_W-1:0]     data_t;      // Register or ALU value
	typedef logic [INSTR_W-1:0]    instr_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [OPCODE_W-1:0]   opcode_t;
	typedef logic [FUNCT_W-1:0]    funct_t;
	typedef logic [IMM_W-1:0]      imm_t;

	// ------------------------------------------------------------
	// Instruction field positions
	// ------------------------------------------------------------
	localparam int OPCODE_LSB = 26;
	localparam int RS_LSB     = 21;
	localparam int RT_LSB     = 16;
	localparam int RD_LSB     = 11;    // Funct and immediate sit at bit 0

	// ------------------------------------------------------------
	// Opcodes
	// ------------------------------------------------------------
	localparam opcode_t OP_RTYPE = 6'd0;
	localparam opcode_t OP_ADDI  = 6'd8;
	localparam opcode_t OP_ANDI  = 6'd12;
	localparam opcode_t OP_ORI   = 6'd13;
	localparam opcode_t OP_LUI   = 6'd15;

	// R-type funct codes
	localparam funct_t FUNCT_ADD = 6'd32;
	localparam funct_t FUNCT_SUB = 6'd34;
	localparam funct_t FUNCT_AND = 6'd36;
	localparam funct_t FUNCT_OR  = 6'd37;
	localparam funct_t FUNCT_SLT = 6'd42;

	// ------------------------------------------------------------
	// ALU operations
	// ------------------------------------------------------------
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,    // Signed compare
		ALU_LUI     // Operand b into the upper half
	} alu_op_e;

endpackage

`default_nettype wire
